/* ctu_top.f */
+incdir+include
src/ctu_pkg.sv
src/ctu_rt_regs.sv
src/ctu_rst_seq.sv
src/ctu_cken_ctl.sv
src/ctu_top.sv
verification/tb_ctu_top.sv

/* include/ctu_params.svh */
`ifndef CTU_PARAMS_SVH
`define CTU_PARAMS_SVH

// Test-register port
`define CTU_RT_DW       32       // Data word width
`define CTU_RT_AW       2        // Word address width

// Register map, word addresses
`define CTU_ADDR_ID     2'd0     // Revision, read only
`define CTU_ADDR_CTRL   2'd1     // Clock selects, force and mode bits
`define CTU_ADDR_CKEN   2'd2     // Cluster enable mask
`define CTU_ADDR_NSTEP  2'd3     // Burst start, burst and reset status

// Reset sequencing
`define CTU_RST_DLY     16       // Cycles until pre-reset release
`define CTU_RST_PIPE    3        // Global reset pipe depth

// Burst clocking
`define CTU_NSTEP_W     8        // Burst count width

// Revision nibbles
`define CTU_JTAG_ID     4'h1
`define CTU_MASK_MAJOR  4'h2
`define CTU_MASK_MINOR  4'h0

`endif

/* src/ctu_cken_ctl.sv */
`timescale 1ns/1ps
`include "ctu_params.svh"

module ctu_cken_ctl
   import ctu_pkg::*;
(
   input  logic                    cmp_clk,
   input  logic                    rst_n,
   input  logic                    grst_l,
   input  ctrl_reg_t               ctrl,
   input  cken_t                   cken_mask,
   input  logic                    nstep_start,
   input  logic [`CTU_NSTEP_W-1:0] nstep_count,
   input  domain_t                 nstep_domain,
   output cken_t                   cken,
   output logic                    nstep_busy,
   output logic [`CTU_NSTEP_W-1:0] nstep_left
);

   logic    start_ok;    // Start taken, idle and nonzero count
   logic    burst_nxt;   // Burst enable for the next cycle
   domain_t burst_dom;   // Domain of the current or last burst
   domain_t dom_act;     // Domain steered by the burst
   domain_t gate;        // Per-group enable before mask
   cken_t   cken_nxt;

   // Widen a per-domain bit to every cluster of that group
   function automatic cken_t spread(domain_t dom);
      cken_t c;
      c.spc   = {8{dom.cmp}};
      c.sctag = {4{dom.cmp}};
      c.fpu   = dom.cmp;
      c.iob   = dom.jbus;
      c.jbi   = dom.jbus;
      c.dram  = dom.dram;
      return c;
   endfunction

   assign nstep_busy = (nstep_left != '0);
   assign start_ok   = nstep_start && !nstep_busy && (nstep_count != '0);

   // Enable lines up with the count, first cycle already on at load
   assign burst_nxt = start_ok || (nstep_left > `CTU_NSTEP_W'(1));
   assign dom_act   = start_ok ? nstep_domain : burst_dom;

   // Burst down-counter
   always_ff @(posedge cmp_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         nstep_left <= '0;
         burst_dom  <= '0;
      end
      else if (start_ok)
      begin
         nstep_left <= nstep_count;
         burst_dom  <= nstep_domain;
      end
      else if (nstep_busy)
         nstep_left <= nstep_left - 1'b1;
   end

   // Burst gating replaces reset gating in the burst domain
   always_comb
   begin
      gate.cmp  = (ctrl.nstep_mode && dom_act.cmp)  ? burst_nxt : grst_l;
      gate.dram = (ctrl.nstep_mode && dom_act.dram) ? burst_nxt : grst_l;
      gate.jbus = (ctrl.nstep_mode && dom_act.jbus) ? burst_nxt : grst_l;
   end

   // Force overrides mask, reset and burst
   assign cken_nxt = (cken_mask & spread(gate)) | spread(ctrl.force_cken);

   always_ff @(posedge cmp_clk or negedge rst_n)
   begin
      if (!rst_n)
         cken <= '0;
      else
         cken <= cken_nxt;
   end

endmodule

/* src/ctu_pkg.sv */
`include "ctu_params.svh"

package ctu_pkg;

   // Test-register request, held by the master until ack
   typedef struct packed {
      logic                  valid;
      logic                  read_write;   // 1 = read
      logic [`CTU_RT_AW-1:0] addr;
      logic [`CTU_RT_DW-1:0] data;
   } rt_req_t;

   typedef struct packed {
      logic                  ack;          // One cycle per request
      logic [`CTU_RT_DW-1:0] data;         // Valid with ack on reads
   } rt_rsp_t;

   // Clock switch source, code 3 rejected on write
   typedef enum logic [1:0] {
      CLK_SRC_PLL    = 2'd0,
      CLK_SRC_BYPASS = 2'd1,
      CLK_SRC_TCK    = 2'd2
   } clk_src_e;

   typedef struct packed {
      logic tck;      // Bit 2
      logic bypass;   // Bit 1
      logic pll;      // Bit 0
   } clk_sel_oh_t;

   // Cluster clock enables
   typedef struct packed {
      logic [7:0] spc;     // Cores, cmp group
      logic [3:0] sctag;   // L2 tags, cmp group
      logic       fpu;     // Cmp group
      logic       iob;     // Jbus group
      logic       jbi;     // Jbus group
      logic       dram;    // Dram group
   } cken_t;

   typedef struct packed {
      logic jbus;
      logic dram;
      logic cmp;
   } domain_t;

   typedef enum logic [1:0] {
      RST_NONE  = 2'd0,
      RST_PWRON = 2'd1,
      RST_WARM  = 2'd2
   } rst_cause_e;

   // Register views of the one data word
   typedef struct packed {
      logic [`CTU_RT_DW-13:0] pad;
      logic                   nstep_mode;      // Burst gating on
      logic                   scanmode;        // Holds DLL reset released
      logic                   ignore_wrm_rst;  // Masks warm reset
      domain_t                force_cken;      // Group forced on
      clk_src_e               sel_jbus;
      clk_src_e               sel_dram;
      clk_src_e               sel_cpu;
   } ctrl_reg_t;

   typedef struct packed {
      logic [`CTU_RT_DW-`CTU_NSTEP_W-7:0] pad;
      rst_cause_e                         cause;   // Read only
      logic                               busy;    // Read only
      domain_t                            domain;
      logic [`CTU_NSTEP_W-1:0]            count;   // Write count, read remaining
   } nstep_reg_t;

   typedef struct packed {
      logic [`CTU_RT_DW-13:0] pad;
      logic [3:0]             jtag_id;
      logic [3:0]             mask_major;
      logic [3:0]             mask_minor;
   } id_reg_t;

   typedef union packed {
      logic [`CTU_RT_DW-1:0] raw;
      ctrl_reg_t             ctrl;
      nstep_reg_t            nstep;
      id_reg_t               id;
   } rt_word_u;

endpackage

/* src/ctu_rst_seq.sv */
`timescale 1ns/1ps
`include "ctu_params.svh"

module ctu_rst_seq
   import ctu_pkg::*;
(
   input  logic       cmp_clk,
   input  logic       rst_n,
   input  logic       warm_rst_l,
   input  ctrl_reg_t  ctrl,
   output logic       grst_l,
   output logic       iodll_rst_l,
   output rst_cause_e rst_cause
);

   localparam int CNT_W = $clog2(`CTU_RST_DLY + 1);

   logic [CNT_W-1:0]         dly_cnt;     // Cycles since sequence start
   logic                     pre_rst_l;   // Release into the pipe
   logic [`CTU_RST_PIPE-1:0] rst_pipe;
   logic                     warm_hit;    // Unmasked warm reset sample

   assign warm_hit  = !warm_rst_l && !ctrl.ignore_wrm_rst;
   assign pre_rst_l = (dly_cnt == CNT_W'(`CTU_RST_DLY));

   // Delay counter, saturates at release
   always_ff @(posedge cmp_clk or negedge rst_n)
   begin
      if (!rst_n)
         dly_cnt <= '0;
      else if (warm_hit)
         dly_cnt <= '0;                  // Restart on warm reset
      else if (!pre_rst_l)
         dly_cnt <= dly_cnt + 1'b1;
   end

   // Global reset pipe
   always_ff @(posedge cmp_clk or negedge rst_n)
   begin
      if (!rst_n)
         rst_pipe <= '0;
      else if (warm_hit)
         rst_pipe <= '0;                 // Drops grst_l next edge
      else
         rst_pipe <= {rst_pipe[`CTU_RST_PIPE-2:0], pre_rst_l};
   end

   // Cause of the last reset
   always_ff @(posedge cmp_clk or negedge rst_n)
   begin
      if (!rst_n)
         rst_cause <= RST_PWRON;
      else if (warm_hit)
         rst_cause <= RST_WARM;
   end

   assign grst_l = rst_pipe[`CTU_RST_PIPE-1];

   // Scan mode keeps the DLLs out of reset
   assign iodll_rst_l = grst_l | ctrl.scanmode;

endmodule

/* src/ctu_rt_regs.sv */
`timescale 1ns/1ps
`include "ctu_params.svh"

module ctu_rt_regs
   import ctu_pkg::*;
(
   input  logic                    cmp_clk,
   input  logic                    rst_n,
   input  rt_req_t                 rt_req,
   input  rst_cause_e              rst_cause,
   input  logic                    nstep_busy,
   input  logic [`CTU_NSTEP_W-1:0] nstep_left,
   output rt_rsp_t                 rt_rsp,
   output ctrl_reg_t               ctrl,
   output cken_t                   cken_mask,
   output logic                    nstep_start,
   output logic [`CTU_NSTEP_W-1:0] nstep_count,
   output domain_t                 nstep_domain,
   output clk_sel_oh_t             sel_cpu,
   output clk_sel_oh_t             sel_dram,
   output clk_sel_oh_t             sel_jbus
);

   rt_word_u              wr_word;     // Write data seen through the addressed view
   rt_word_u              rd_word;     // Read mux
   ctrl_reg_t             ctrl_nxt;    // CTRL after legality filter
   logic                  ack_q;
   logic                  accept;      // Request taken this edge
   logic                  wr_en;
   logic                  rd_en;
   logic [`CTU_RT_DW-1:0] rd_data_q;

   // Only the three listed sources pass
   function automatic logic src_legal(clk_src_e src);
      return (src == CLK_SRC_PLL) || (src == CLK_SRC_BYPASS) || (src == CLK_SRC_TCK);
   endfunction

   function automatic clk_sel_oh_t to_onehot(clk_src_e src);
      clk_sel_oh_t oh;
      oh = '0;
      case (src)
         CLK_SRC_BYPASS: oh.bypass = 1'b1;
         CLK_SRC_TCK:    oh.tck    = 1'b1;
         default:        oh.pll    = 1'b1;   // Stored code is never illegal
      endcase
      return oh;
   endfunction

   // No new accept during our own ack cycle
   assign accept  = rt_req.valid && !ack_q;
   assign wr_en   = accept && !rt_req.read_write;
   assign rd_en   = accept && rt_req.read_write;
   assign wr_word = rt_word_u'(rt_req.data);

   // Illegal select codes keep the old source
   always_comb
   begin
      ctrl_nxt     = wr_word.ctrl;
      ctrl_nxt.pad = '0;
      if (!src_legal(wr_word.ctrl.sel_cpu))
         ctrl_nxt.sel_cpu = ctrl.sel_cpu;
      if (!src_legal(wr_word.ctrl.sel_dram))
         ctrl_nxt.sel_dram = ctrl.sel_dram;
      if (!src_legal(wr_word.ctrl.sel_jbus))
         ctrl_nxt.sel_jbus = ctrl.sel_jbus;
   end

   always_comb
   begin
      rd_word = '0;
      case (rt_req.addr)
         `CTU_ADDR_ID:
         begin
            rd_word.id.jtag_id    = `CTU_JTAG_ID;
            rd_word.id.mask_major = `CTU_MASK_MAJOR;
            rd_word.id.mask_minor = `CTU_MASK_MINOR;
         end
         `CTU_ADDR_CTRL:
            rd_word.ctrl = ctrl;
         `CTU_ADDR_CKEN:
            rd_word.raw[$bits(cken_t)-1:0] = cken_mask;   // Low half only
         default:
         begin
            rd_word.nstep.count = nstep_left;   // Remaining burst cycles
            rd_word.nstep.busy  = nstep_busy;
            rd_word.nstep.cause = rst_cause;
         end
      endcase
   end

   // Handshake and control registers
   always_ff @(posedge cmp_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ack_q       <= 1'b0;
         ctrl        <= '0;   // All selects PLL, modes off
         cken_mask   <= '0;
         nstep_start <= 1'b0;
      end
      else
      begin
         ack_q       <= accept;
         nstep_start <= wr_en && (rt_req.addr == `CTU_ADDR_NSTEP);   // One-cycle pulse
         if (wr_en && (rt_req.addr == `CTU_ADDR_CTRL))
            ctrl <= ctrl_nxt;
         if (wr_en && (rt_req.addr == `CTU_ADDR_CKEN))
            cken_mask <= cken_t'(wr_word.raw[$bits(cken_t)-1:0]);
      end
   end

   // Read data and burst parameters
   always_ff @(posedge cmp_clk)
   begin
      if (rd_en)
         rd_data_q <= rd_word.raw;
      if (wr_en && (rt_req.addr == `CTU_ADDR_NSTEP))
      begin
         nstep_count  <= wr_word.nstep.count;
         nstep_domain <= wr_word.nstep.domain;
      end
   end

   assign rt_rsp = '{ack: ack_q, data: rd_data_q};

   // Clock switch selects, one-hot by construction
   assign sel_cpu  = to_onehot(ctrl.sel_cpu);
   assign sel_dram = to_onehot(ctrl.sel_dram);
   assign sel_jbus = to_onehot(ctrl.sel_jbus);

endmodule

/* src/ctu_top.sv */
`timescale 1ns/1ps
`include "ctu_params.svh"

module ctu_top
   import ctu_pkg::*;
(
   input  logic        cmp_clk,
   input  logic        rst_n,
   input  logic        warm_rst_l,
   input  rt_req_t     rt_req,
   output rt_rsp_t     rt_rsp,
   output cken_t       cken,
   output clk_sel_oh_t sel_cpu,
   output clk_sel_oh_t sel_dram,
   output clk_sel_oh_t sel_jbus,
   output logic        grst_l,
   output logic        iodll_rst_l
);

   ctrl_reg_t               ctrl;           // Control word to sequencer and gating
   cken_t                   cken_mask;
   logic                    nstep_start;
   logic [`CTU_NSTEP_W-1:0] nstep_count;
   domain_t                 nstep_domain;
   logic                    nstep_busy;
   logic [`CTU_NSTEP_W-1:0] nstep_left;     // Burst status back to registers
   rst_cause_e              rst_cause;

   ctu_rt_regs u_rt_regs (
      .cmp_clk      (cmp_clk),
      .rst_n        (rst_n),
      .rt_req       (rt_req),
      .rst_cause    (rst_cause),
      .nstep_busy   (nstep_busy),
      .nstep_left   (nstep_left),
      .rt_rsp       (rt_rsp),
      .ctrl         (ctrl),
      .cken_mask    (cken_mask),
      .nstep_start  (nstep_start),
      .nstep_count  (nstep_count),
      .nstep_domain (nstep_domain),
      .sel_cpu      (sel_cpu),
      .sel_dram     (sel_dram),
      .sel_jbus     (sel_jbus)
   );

   ctu_rst_seq u_rst_seq (
      .cmp_clk      (cmp_clk),
      .rst_n        (rst_n),
      .warm_rst_l   (warm_rst_l),
      .ctrl         (ctrl),
      .grst_l       (grst_l),
      .iodll_rst_l  (iodll_rst_l),
      .rst_cause    (rst_cause)
   );

   ctu_cken_ctl u_cken_ctl (
      .cmp_clk      (cmp_clk),
      .rst_n        (rst_n),
      .grst_l       (grst_l),
      .ctrl         (ctrl),
      .cken_mask    (cken_mask),
      .nstep_start  (nstep_start),
      .nstep_count  (nstep_count),
      .nstep_domain (nstep_domain),
      .cken         (cken),
      .nstep_busy   (nstep_busy),
      .nstep_left   (nstep_left)
   );

endmodule

/* verification/tb_ctu_top.sv */
`timescale 1ns/1ps
`include "ctu_params.svh"

module tb_ctu_top
   import ctu_pkg::*;
();

   localparam int ACK_TIMEOUT  = 20;                              // Cycles per handshake
   localparam int GRST_TIMEOUT = 200;                             // Cycles for reset release
   localparam int RST_EDGES    = `CTU_RST_DLY + `CTU_RST_PIPE;   // Start edge to grst_l high
   localparam int NSTEP_LEN    = 6;                               // Burst length under test
   localparam logic [15:0] CMP_BITS = 16'hfff8;                   // spc, sctag and fpu

   logic        cmp_clk;
   logic        rst_n;
   logic        warm_rst_l;
   rt_req_t     rt_req;
   rt_rsp_t     rt_rsp;
   cken_t       cken;
   clk_sel_oh_t sel_cpu;
   clk_sel_oh_t sel_dram;
   clk_sel_oh_t sel_jbus;
   logic        grst_l;
   logic        iodll_rst_l;

   integer      seed;
   string       cur_test;
   int          test_errors;
   int          total_errors;
   int          tests_run;
   int          tests_failed;
   logic [15:0] cur_mask;        // Mask last written to CKEN

   ctu_top ctu_top_inst (.*);

   initial
   begin
      cmp_clk = 1'b0;
      forever
         #20 cmp_clk = ~cmp_clk;   // 40 ns period
   end

   task automatic check_value(input string what, input logic [31:0] want,
                              input logic [31:0] got);
      assert (got === want)
      else
      begin
         $display("error %s %s: expected %h, actual %h", cur_test, what, want, got);
         test_errors++;
      end
   endtask

   task automatic check_done(input logic done, input string what);
      assert (done)
      else
      begin
         $display("%s timed out: %s", cur_test, what);
         test_errors++;
      end
   endtask

   // One handshake, returns on the falling edge that shows ack
   task automatic bus_cycle(input logic rd, input logic [1:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
      int cycles;
      rt_req = '{valid: 1'b1, read_write: rd, addr: addr, data: wdata};
      cycles = 0;
      do
      begin
         @(negedge cmp_clk);
         cycles++;
      end
      while (rt_rsp.ack !== 1'b1 && cycles < ACK_TIMEOUT);
      rdata  = rt_rsp.data;              // Valid in the ack cycle
      rt_req = '0;                       // Valid drops before the next edge
      check_done(rt_rsp.ack === 1'b1, "no ack from the register port");
   endtask

   task automatic rt_write(input logic [1:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      bus_cycle(1'b0, addr, data, unused);
   endtask

   task automatic rt_read(input logic [1:0] addr, output logic [31:0] data);
      bus_cycle(1'b1, addr, 32'h0, data);
   endtask

   // CTRL layout from bit 0 up
   function automatic logic [31:0] ctrl_word(input logic [1:0] cpu, input logic [1:0] dram,
                                             input logic [1:0] jbus, input logic [2:0] frc,
                                             input logic ign, input logic scan,
                                             input logic nstep);
      return {20'd0, nstep, scan, ign, frc, jbus, dram, cpu};
   endfunction

   function automatic logic [31:0] nstep_word(input logic [7:0] count, input logic [2:0] dom);
      return {21'd0, dom, count};
   endfunction

   function automatic logic [2:0] onehot_of(input logic [1:0] code);
      return 3'b001 << code;
   endfunction

   // Counts rising edges until grst_l is high
   task automatic wait_grst_release(input logic [15:0] cken_low, output int edges);
      edges = 0;
      while (grst_l !== 1'b1 && edges < GRST_TIMEOUT)
      begin
         @(negedge cmp_clk);
         edges++;
         check_value("cken while grst_l low", cken_low, cken);
      end
      check_done(grst_l === 1'b1, "grst_l was never released");
   endtask

   task automatic finish_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors != 0)
         tests_failed++;
      $display("%s finished with %0d errors", cur_test, test_errors);
   endtask

   task automatic power_on_reset();
      int          edges;
      logic [31:0] rdata;
      rt_word_u    word;
      cur_test    = "power_on_reset";
      test_errors = 0;
      check_value("grst_l at release", 1'b0, grst_l);
      check_value("iodll_rst_l at release", 1'b0, iodll_rst_l);
      check_value("ack at release", 1'b0, rt_rsp.ack);
      wait_grst_release(16'h0, edges);
      check_value("release edges", RST_EDGES, edges);
      check_value("sel_cpu", 3'b001, sel_cpu);
      check_value("sel_dram", 3'b001, sel_dram);
      check_value("sel_jbus", 3'b001, sel_jbus);
      rt_read(`CTU_ADDR_NSTEP, rdata);
      word.raw = rdata;
      check_value("reset cause", RST_PWRON, word.nstep.cause);
      rt_read(`CTU_ADDR_CKEN, rdata);
      check_value("mask after reset", 32'h0, rdata);
      check_value("cken after release", 16'h0, cken);   // Zero mask keeps all groups off
      finish_test();
   endtask

   task automatic id_and_ctrl();
      logic [31:0] rdata;
      logic [31:0] id_word;
      cur_test    = "id_and_ctrl";
      test_errors = 0;
      id_word     = {20'd0, `CTU_JTAG_ID, `CTU_MASK_MAJOR, `CTU_MASK_MINOR};
      rt_write(`CTU_ADDR_ID, 32'hffff_ffff);   // Read only register
      rt_read(`CTU_ADDR_ID, rdata);
      check_value("id word", id_word, rdata);
      rt_write(`CTU_ADDR_CTRL, ctrl_word(2'd1, 2'd2, 2'd0, 3'b000, 1'b0, 1'b0, 1'b0));
      check_value("sel_cpu", onehot_of(2'd1), sel_cpu);
      check_value("sel_dram", onehot_of(2'd2), sel_dram);
      check_value("sel_jbus", onehot_of(2'd0), sel_jbus);
      // Illegal cpu code keeps the old source while other fields update
      rt_write(`CTU_ADDR_CTRL, ctrl_word(2'd3, 2'd1, 2'd2, 3'b000, 1'b0, 1'b1, 1'b0));
      check_value("sel_cpu kept", onehot_of(2'd1), sel_cpu);
      check_value("sel_dram", onehot_of(2'd1), sel_dram);
      check_value("sel_jbus", onehot_of(2'd2), sel_jbus);
      check_value("one-hot selects", 3'b111,
                  {$onehot(sel_cpu), $onehot(sel_dram), $onehot(sel_jbus)});
      rt_read(`CTU_ADDR_CTRL, rdata);
      check_value("ctrl readback",
                  ctrl_word(2'd1, 2'd1, 2'd2, 3'b000, 1'b0, 1'b1, 1'b0), rdata);
      finish_test();
   endtask

   task automatic mask_and_force();
      int          edges;
      logic [31:0] rnd;
      logic [31:0] rdata;
      cur_test    = "mask_and_force";
      test_errors = 0;
      rnd         = $random(seed);
      cur_mask    = rnd[15:0];
      rt_write(`CTU_ADDR_CTRL, 32'h0);
      rt_write(`CTU_ADDR_CKEN, {16'd0, cur_mask});
      @(negedge cmp_clk);                      // cken lags the mask by one cycle
      check_value("cken from mask", cur_mask, cken);
      rt_read(`CTU_ADDR_CKEN, rdata);
      check_value("mask readback", {16'd0, cur_mask}, rdata);
      rt_write(`CTU_ADDR_CTRL, ctrl_word(2'd0, 2'd0, 2'd0, 3'b001, 1'b0, 1'b1, 1'b0));
      @(negedge cmp_clk);
      check_value("cken with cmp forced", cur_mask | CMP_BITS, cken);
      warm_rst_l = 1'b0;                       // Two-cycle warm reset
      @(negedge cmp_clk);
      check_value("grst_l in warm reset", 1'b0, grst_l);
      check_value("iodll_rst_l in scan mode", 1'b1, iodll_rst_l);
      @(negedge cmp_clk);
      warm_rst_l = 1'b1;
      check_value("cken forced in warm reset", CMP_BITS, cken);
      check_value("iodll_rst_l in scan mode", 1'b1, iodll_rst_l);
      wait_grst_release(CMP_BITS, edges);      // Only the forced group runs
      check_value("warm release edges", RST_EDGES, edges);
      @(negedge cmp_clk);
      check_value("cken after release", cur_mask | CMP_BITS, cken);
      rt_write(`CTU_ADDR_CTRL, 32'h0);
      finish_test();
   endtask

   task automatic nstep_burst();
      logic [31:0] rdata;
      rt_word_u    word;
      logic [15:0] want;
      int          on_cnt;
      logic        run_ended;
      logic        gap;
      cur_test    = "nstep_burst";
      test_errors = 0;
      cur_mask    = cur_mask | 16'h0100;       // At least one core enabled
      rt_write(`CTU_ADDR_CKEN, {16'd0, cur_mask});
      rt_write(`CTU_ADDR_CTRL, ctrl_word(2'd0, 2'd0, 2'd0, 3'b000, 1'b0, 1'b0, 1'b1));
      rt_write(`CTU_ADDR_NSTEP, nstep_word(NSTEP_LEN, 3'b001));
      // Cmp group on for NSTEP_LEN cycles, one cycle after the start pulse
      for (int i = 1; i <= NSTEP_LEN + 4; i++)
      begin
         @(negedge cmp_clk);
         want = (i <= NSTEP_LEN) ? cur_mask : (cur_mask & ~CMP_BITS);
         check_value("cken in burst", want, cken);
      end
      rt_read(`CTU_ADDR_NSTEP, rdata);
      word.raw = rdata;
      check_value("busy after burst", 1'b0, word.nstep.busy);
      check_value("count after burst", 0, word.nstep.count);
      check_value("cken idle", cur_mask & ~CMP_BITS, cken);
      on_cnt    = 0;
      run_ended = 1'b0;
      gap       = 1'b0;
      fork
         begin
            rt_write(`CTU_ADDR_NSTEP, nstep_word(NSTEP_LEN, 3'b001));
            rt_write(`CTU_ADDR_NSTEP, nstep_word(8'd40, 3'b001));   // Lands while busy
         end
         for (int i = 0; i < 4 * NSTEP_LEN + 8; i++)
         begin
            @(negedge cmp_clk);
            check_value("cken outside cmp", cur_mask & ~CMP_BITS, cken & ~CMP_BITS);
            if ((cken & CMP_BITS) != 16'h0)
            begin
               check_value("cmp enables", cur_mask & CMP_BITS, cken & CMP_BITS);
               on_cnt++;
               gap = gap | run_ended;          // Second run after a gap
            end
            else if (on_cnt != 0)
               run_ended = 1'b1;
         end
      join
      check_value("burst length with restart", NSTEP_LEN, on_cnt);
      check_value("burst in one run", 1'b0, gap);
      rt_write(`CTU_ADDR_CTRL, 32'h0);
      finish_test();
   endtask

   task automatic warm_reset();
      int          edges;
      logic [31:0] rdata;
      rt_word_u    word;
      cur_test    = "warm_reset";
      test_errors = 0;
      @(negedge cmp_clk);
      check_value("cken before pulse", cur_mask, cken);
      warm_rst_l = 1'b0;                       // One-cycle pulse
      @(negedge cmp_clk);
      warm_rst_l = 1'b1;
      check_value("grst_l in warm reset", 1'b0, grst_l);
      wait_grst_release(16'h0, edges);
      check_value("warm release edges", RST_EDGES, edges);
      @(negedge cmp_clk);
      check_value("cken after release", cur_mask, cken);
      rt_read(`CTU_ADDR_NSTEP, rdata);
      word.raw = rdata;
      check_value("reset cause", RST_WARM, word.nstep.cause);
      rt_write(`CTU_ADDR_CTRL, ctrl_word(2'd0, 2'd0, 2'd0, 3'b000, 1'b1, 1'b0, 1'b0));
      warm_rst_l = 1'b0;
      repeat (2) @(negedge cmp_clk);
      warm_rst_l = 1'b1;
      for (int i = 0; i < 4; i++)
      begin
         check_value("grst_l with warm reset ignored", 1'b1, grst_l);
         check_value("cken with warm reset ignored", cur_mask, cken);
         @(negedge cmp_clk);
      end
      finish_test();
   endtask

   initial
   begin
      seed         = 32'h9d119ac5;
      rst_n        = 1'b0;
      warm_rst_l   = 1'b1;
      rt_req       = '0;
      cur_mask     = 16'h0;
      tests_run    = 0;
      tests_failed = 0;
      total_errors = 0;
      repeat (5) @(negedge cmp_clk);           // Power-on reset
      rst_n = 1'b1;
      power_on_reset();
      id_and_ctrl();
      mask_and_force();
      nstep_burst();
      warm_reset();
      $display("summary: %0d tests, %0d failed, %0d errors",
               tests_run, tests_failed, total_errors);
      if (total_errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule
